// File: src/n64_video_pkg.sv
// n64 video deblur shared definitions
// bus widths, pixel and config structs, APB register map

package n64_video_pkg;

  localparam int COLOR_W = 7;  // one colour component on the bus

  // sync word, bit order as on d_i[3:0]
  typedef struct packed {
    logic nvsync;  // bit 3
    logic nclamp;
    logic nhsync;
    logic ncsync;  // bit 0
  } vsync_t;

  // one complete pixel, 25 bits
  typedef struct packed {
    vsync_t             sync;
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } pixel_t;

  // demux -> estimator
  typedef struct packed {
    logic       valid;     // one cycle per pixel, on the blue word
    pixel_t     cur;       // pixel just completed
    pixel_t     pre;       // its left neighbour
    logic [1:0] data_cnt;  // word position 0..3
  } pix_bus_t;

  // estimator -> output stage
  typedef struct packed {
    logic   valid;
    logic   blur_pix;  // 1 = pixel in blurred phase
    pixel_t pix;
  } tagged_pix_t;

  // mode bits, CTRL[3:0]
  typedef struct packed {
    logic ndeblur_man;    // manual setting, low = deblur
    logic nforce_deblur;  // high = follow estimator
    logic n64_480i;       // interlaced, no estimation
    logic vmode;          // blur phase at line start
  } deblur_cfg_t;

  ////////////////////////////////////////
  // register map
  localparam logic [2:0] ADDR_CTRL   = 3'h0;
  localparam logic [2:0] ADDR_STATUS = 3'h4;

  localparam deblur_cfg_t CTRL_RST = 4'b1100;  // ndeblur_man=1, nforce_deblur=1

  localparam int STAT_NDO_BIT   = 0;   // ndo_deblur
  localparam int STAT_NBLUR_BIT = 1;   // nblur_n64
  localparam int STAT_TREND_LSB = 16;  // trend field start

endpackage

// File: src/n64_vdemux.sv
// n64 video demux, stage 1
// assembles sync/r/g/b bus words into pixels and keeps the left neighbour

`timescale 1ns/1ps

module n64_vdemux
  import n64_video_pkg::*;
(
  input  logic               nCLK,
  input  logic               nRST,
  input  logic               nDSYNC_i,
  input  logic [COLOR_W-1:0] d_i,
  output pix_bus_t           pix_o
);

  logic [1:0]         word_cnt;  // expected position of the next word
  logic [1:0]         word_pos;  // position of the word on d_i now
  logic               synced_q;  // first sync word seen
  logic               valid_q;
  logic [1:0]         cnt_q;
  vsync_t             sync_q;    // words collected so far
  logic [COLOR_W-1:0] r_q;
  logic [COLOR_W-1:0] g_q;
  pixel_t             cur_q;
  pixel_t             pre_q;

  assign word_pos = nDSYNC_i ? word_cnt : 2'd0;  // strobe realigns the count

  ////////////////////////////////////////
  // word counter

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      word_cnt <= 2'd0;
      synced_q <= 1'b0;
      valid_q  <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      word_cnt <= word_pos + 2'd1;  // wraps 3 -> 0
      if (!nDSYNC_i)
        synced_q <= 1'b1;
      valid_q <= synced_q && (word_pos == 2'd3);  // pulse on blue word
      cnt_q   <= word_pos;
    end
  end

  ////////////////////////////////////////
  // pixel assembly

  always_ff @(negedge nCLK) begin
    case (word_pos)
      2'd0: sync_q <= vsync_t'(d_i[3:0]);  // sync bits in the low nibble
      2'd1: r_q    <= d_i;
      2'd2: g_q    <= d_i;
      default: begin
        cur_q <= '{sync: sync_q, r: r_q, g: g_q, b: d_i};
        pre_q <= cur_q;  // shift last pixel to neighbour slot
      end
    endcase
  end

  assign pix_o = '{valid: valid_q, cur: cur_q, pre: pre_q, data_cnt: cnt_q};

  // sync strobe must land on a pixel boundary once locked
  a_dsync_at_word0: assert property (@(negedge nCLK) disable iff (!nRST)
    (!nDSYNC_i && synced_q) |-> (word_cnt == 2'd0));

endmodule

// File: src/n64_deblur.sv
// n64 blur estimator, stage 2
// tracks blur phase, counts gradient reversals, filters the per-frame
// trend and decides the deblur setting at every vsync edge

`timescale 1ns/1ps

module n64_deblur
  import n64_video_pkg::*;
#(
  parameter int TREND_W = 9
) (
  input  logic               nCLK,
  input  logic               nRST,
  input  pix_bus_t           pix_i,
  input  deblur_cfg_t        cfg_i,
  output tagged_pix_t        pix_o,
  output logic               ndo_deblur_o,
  output logic               nblur_n64_o,
  output logic [TREND_W-1:0] trend_o
);

  localparam logic [TREND_W-1:0] TREND_INIT = {1'b1, {(TREND_W-1){1'b0}}};  // half scale
  localparam logic [TREND_W-1:0] TREND_MAX  = {TREND_W{1'b1}};

  typedef logic [1:0] grad_t;  // {up, down}, 00 = flat

  // direction of the two colour MSBs from left neighbour to current
  function automatic grad_t grad_of(input logic [COLOR_W-1:0] p, input logic [COLOR_W-1:0] c);
    logic [1:0] pm;
    logic [1:0] cm;
    pm = p[COLOR_W-1 -: 2];
    cm = c[COLOR_W-1 -: 2];
    return {pm < cm, pm > cm};
  endfunction

  logic               pix_stb;      // full pixel present
  logic               pre_ok_q;     // neighbour slot holds a real pixel
  logic               frame_edge;   // falling nvsync between sync words
  logic               csync_rise;
  logic               blur_q;       // phase of the last pixel
  logic               blur_cur;     // phase of the current pixel
  grad_t [2:0]        dir_cur;      // r, g, b
  grad_t [2:0]        grad_q;       // recorded on sharp pixel
  logic               all_rev;
  logic [1:0]         est_cnt_q;    // reversals this frame, saturating
  logic               run_est_q;    // frame fully seen in 240p
  logic [TREND_W-1:0] trend_q;
  logic               nblur_q;      // 1 = console blur estimated off
  logic               ndo_q;
  logic               tag_valid_q;
  logic               tag_blur_q;
  pixel_t             tag_pix_q;

  assign pix_stb    = pix_i.valid && (pix_i.data_cnt == 2'd3);
  assign frame_edge = pix_stb && pre_ok_q && pix_i.pre.sync.nvsync && !pix_i.cur.sync.nvsync;
  assign csync_rise = pix_stb && pre_ok_q && !pix_i.pre.sync.ncsync && pix_i.cur.sync.ncsync;

  assign blur_cur = csync_rise ? ~cfg_i.vmode : ~blur_q;  // line start reloads the phase

  assign dir_cur[2] = grad_of(pix_i.pre.r, pix_i.cur.r);
  assign dir_cur[1] = grad_of(pix_i.pre.g, pix_i.cur.g);
  assign dir_cur[0] = grad_of(pix_i.pre.b, pix_i.cur.b);

  // both bits flip only when a non-flat direction turns round
  assign all_rev = (&(grad_q[2] ^ dir_cur[2])) &&
                   (&(grad_q[1] ^ dir_cur[1])) &&
                   (&(grad_q[0] ^ dir_cur[0]));

  ////////////////////////////////////////
  // estimation and trend filter

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      pre_ok_q  <= 1'b0;
      blur_q    <= 1'b0;
      grad_q    <= '0;
      est_cnt_q <= 2'd0;
      run_est_q <= 1'b0;
      trend_q   <= TREND_INIT;
      nblur_q   <= 1'b1;
      ndo_q     <= 1'b1;
    end else if (pix_stb) begin
      pre_ok_q <= 1'b1;
      blur_q   <= blur_cur;
      if (cfg_i.n64_480i) begin
        run_est_q <= 1'b0;  // skip next 240p frame too
      end else begin
        if (!blur_cur)
          grad_q <= dir_cur;  // sharp pixel
        else if (all_rev && (est_cnt_q != 2'd3))
          est_cnt_q <= est_cnt_q + 2'd1;
        if (frame_edge) begin
          if (run_est_q && est_cnt_q[1])
            trend_q <= (trend_q == TREND_MAX) ? trend_q : trend_q + 1'b1;
          else
            trend_q <= (trend_q == '0) ? trend_q : trend_q - 1'b1;
          nblur_q   <= trend_q[TREND_W-1];  // msb before update
          est_cnt_q <= 2'd0;
          run_est_q <= 1'b1;
        end
      end
      // new setting once per frame
      if (frame_edge)
        ndo_q <= cfg_i.n64_480i | (cfg_i.nforce_deblur ? nblur_q : cfg_i.ndeblur_man);
    end
  end

  ////////////////////////////////////////
  // tagged pixel to output stage

  always_ff @(negedge nCLK) begin
    if (!nRST)
      tag_valid_q <= 1'b0;
    else
      tag_valid_q <= pix_stb;
  end

  always_ff @(negedge nCLK) begin
    tag_blur_q <= blur_cur;
    tag_pix_q  <= pix_i.cur;
  end

  assign pix_o        = '{valid: tag_valid_q, blur_pix: tag_blur_q, pix: tag_pix_q};
  assign ndo_deblur_o = ndo_q;
  assign nblur_n64_o  = nblur_q;
  assign trend_o      = trend_q;

  // trend saturates at both ends
  a_trend_no_wrap_hi: assert property (@(negedge nCLK) disable iff (!nRST)
    (trend_q == TREND_MAX) |=> (trend_q != '0));
  a_trend_no_wrap_lo: assert property (@(negedge nCLK) disable iff (!nRST)
    (trend_q == '0) |=> (trend_q != TREND_MAX));

endmodule

// File: src/n64_deblur_out.sv
// n64 deblur output, stage 3
// repeats the last sharp pixel over blurred ones when deblur is active

`timescale 1ns/1ps

module n64_deblur_out
  import n64_video_pkg::*;
(
  input  logic        nCLK,
  input  logic        nRST,
  input  tagged_pix_t pix_i,
  input  logic        ndo_deblur_i,
  output pixel_t      vout_o,
  output logic        vout_valid_o
);

  logic [COLOR_W-1:0] sharp_r_q;   // colours of last sharp pixel
  logic [COLOR_W-1:0] sharp_g_q;
  logic [COLOR_W-1:0] sharp_b_q;
  logic               sharp_ok_q;  // a sharp pixel has been held
  logic               use_sharp;

  // low ndo_deblur means deblur on
  assign use_sharp = !ndo_deblur_i && pix_i.blur_pix && sharp_ok_q;

  ////////////////////////////////////////
  // control

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      vout_valid_o <= 1'b0;
      sharp_ok_q   <= 1'b0;
    end else begin
      vout_valid_o <= pix_i.valid;
      if (pix_i.valid && !pix_i.blur_pix)
        sharp_ok_q <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // pixel path

  always_ff @(negedge nCLK) begin
    if (pix_i.valid) begin
      if (!pix_i.blur_pix) begin  // remember sharp colours
        sharp_r_q <= pix_i.pix.r;
        sharp_g_q <= pix_i.pix.g;
        sharp_b_q <= pix_i.pix.b;
      end
      vout_o.sync <= pix_i.pix.sync;  // sync always from current pixel
      vout_o.r    <= use_sharp ? sharp_r_q : pix_i.pix.r;
      vout_o.g    <= use_sharp ? sharp_g_q : pix_i.pix.g;
      vout_o.b    <= use_sharp ? sharp_b_q : pix_i.pix.b;
    end
  end

endmodule

// File: src/n64_cfg_apb.sv
// deblur config registers on APB
// CTRL holds the mode bits, STATUS reads back the estimator state

`timescale 1ns/1ps

module n64_cfg_apb
  import n64_video_pkg::*;
#(
  parameter int TREND_W = 9
) (
  input  logic               nCLK,
  input  logic               nRST,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [2:0]         paddr_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  input  logic               ndo_deblur_i,
  input  logic               nblur_n64_i,
  input  logic [TREND_W-1:0] trend_i,
  output deblur_cfg_t        cfg_o
);

  deblur_cfg_t ctrl_q;
  logic        access;    // APB access phase
  logic        wr_ctrl;
  logic [31:0] status_w;

  assign access  = psel_i && penable_i;
  assign wr_ctrl = access && pwrite_i && (paddr_i == ADDR_CTRL);  // STATUS is read only

  ////////////////////////////////////////
  // CTRL register

  always_ff @(negedge nCLK) begin
    if (!nRST)
      ctrl_q <= CTRL_RST;
    else if (wr_ctrl)
      ctrl_q <= deblur_cfg_t'(pwdata_i[3:0]);
  end

  assign cfg_o = ctrl_q;

  ////////////////////////////////////////
  // read path

  always_comb begin
    status_w                                = '0;
    status_w[STAT_NDO_BIT]                  = ndo_deblur_i;
    status_w[STAT_NBLUR_BIT]                = nblur_n64_i;
    status_w[STAT_TREND_LSB +: TREND_W]     = trend_i;  // trend from bit 16
  end

  always_comb begin
    prdata_o = '0;
    if (psel_i && !pwrite_i) begin  // valid through setup and access
      case (paddr_i)
        ADDR_CTRL:   prdata_o = {28'd0, ctrl_q};
        ADDR_STATUS: prdata_o = status_w;
        default:     prdata_o = '0;
      endcase
    end
  end

  // access phase only after a setup cycle
  a_penable_after_psel: assert property (@(negedge nCLK) disable iff (!nRST)
    penable_i |-> (psel_i && $past(psel_i)));

endmodule

// File: src/n64_video_top.sv
// n64 video deblur top level
// demux -> estimator -> output stage, mode bits from the APB block

`timescale 1ns/1ps

module n64_video_top
  import n64_video_pkg::*;
#(
  parameter int TREND_W = 9
) (
  input  logic               nCLK,
  input  logic               nRST,
  input  logic               nDSYNC_i,
  input  logic [COLOR_W-1:0] d_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [2:0]         paddr_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output pixel_t             vout_o,
  output logic               vout_valid_o
);

  pix_bus_t           demux_pix;  // stage 1 -> 2
  tagged_pix_t        tag_pix;    // stage 2 -> 3
  deblur_cfg_t        cfg;
  logic               ndo_deblur;
  logic               nblur_n64;
  logic [TREND_W-1:0] trend;

  ////////////////////////////////////////
  // video path

  n64_vdemux i_vdemux (
    .nCLK     (nCLK),
    .nRST     (nRST),
    .nDSYNC_i (nDSYNC_i),
    .d_i      (d_i),
    .pix_o    (demux_pix)
  );

  n64_deblur #(
    .TREND_W (TREND_W)
  ) i_deblur (
    .nCLK         (nCLK),
    .nRST         (nRST),
    .pix_i        (demux_pix),
    .cfg_i        (cfg),
    .pix_o        (tag_pix),
    .ndo_deblur_o (ndo_deblur),
    .nblur_n64_o  (nblur_n64),
    .trend_o      (trend)
  );

  n64_deblur_out i_deblur_out (
    .nCLK         (nCLK),
    .nRST         (nRST),
    .pix_i        (tag_pix),
    .ndo_deblur_i (ndo_deblur),
    .vout_o       (vout_o),
    .vout_valid_o (vout_valid_o)
  );

  // register block
  n64_cfg_apb #(
    .TREND_W (TREND_W)
  ) i_cfg_apb (
    .nCLK         (nCLK),
    .nRST         (nRST),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .ndo_deblur_i (ndo_deblur),
    .nblur_n64_i  (nblur_n64),
    .trend_i      (trend),
    .cfg_o        (cfg)
  );

endmodule

// File: verification/n64_tb_clk.sv
// testbench clock source
// free-running clock, starts low

`timescale 1ns/1ps

module n64_tb_clk #(
  parameter real PERIOD_NS = 20.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // 50% duty
  end

endmodule

// File: verification/n64_video_tb.sv
// n64 video deblur testbench
// drives bus frames and APB from the vector file, models the estimator
// and output stage, checks every output pixel and the STATUS register

`timescale 1ns/1ps

module n64_video_tb
  import n64_video_pkg::*;
;

  localparam int TREND_W  = 9;
  localparam int ACTIVE_N = 8;  // active pixels per frame
  localparam int SYNC_N   = 2;  // vsync pixels closing a frame
  localparam logic [1:0] D_FLAT = 2'd0;
  localparam logic [1:0] D_UP   = 2'd1;
  localparam logic [1:0] D_DN   = 2'd2;

  logic               nCLK;
  logic               nRST;
  logic               nDSYNC_i;
  logic [COLOR_W-1:0] d_i;
  logic               psel_i;
  logic               penable_i;
  logic               pwrite_i;
  logic [2:0]         paddr_i;
  logic [31:0]        pwdata_i;
  logic [31:0]        prdata_o;
  pixel_t             vout_o;
  logic               vout_valid_o;

  int unsigned cyc;
  pixel_t      exp_q[$];  // expected output pixels in order
  int unsigned cyc_q[$];  // cycle of each blue word

  // reference model state
  deblur_cfg_t        m_cfg;
  pixel_t             m_pre;
  logic               m_pre_ok;
  logic               m_blur;
  logic [1:0]         m_grad [3];
  int                 m_cnt;
  logic               m_run;
  logic [TREND_W-1:0] m_trend;
  logic               m_nblur;
  logic               m_ndo;
  logic               m_sharp_ok;
  pixel_t             m_sharp;

  n64_tb_clk #(.PERIOD_NS(20.0)) i_clk (.clk_o(nCLK));

  n64_video_top #(
    .TREND_W (TREND_W)
  ) i_dut (
    .nCLK         (nCLK),
    .nRST         (nRST),
    .nDSYNC_i     (nDSYNC_i),
    .d_i          (d_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .vout_o       (vout_o),
    .vout_valid_o (vout_valid_o)
  );

  always @(negedge nCLK) cyc <= cyc + 1;  // counted away from the drive edge

  ////////////////////////////////////////
  // failure reporting and compares

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  ////////////////////////////////////////
  // reference model

  function automatic logic [1:0] dir_of(input logic [COLOR_W-1:0] p, input logic [COLOR_W-1:0] c);
    if (c[COLOR_W-1 -: 2] > p[COLOR_W-1 -: 2])
      return D_UP;
    if (c[COLOR_W-1 -: 2] < p[COLOR_W-1 -: 2])
      return D_DN;
    return D_FLAT;
  endfunction

  function automatic logic reverses(input logic [1:0] g, input logic [1:0] d);
    return ((g == D_UP) && (d == D_DN)) || ((g == D_DN) && (d == D_UP));
  endfunction

  task automatic reset_model();
    m_pre      = '0;
    m_pre_ok   = 1'b0;
    m_blur     = 1'b0;
    m_grad     = '{D_FLAT, D_FLAT, D_FLAT};
    m_cnt      = 0;
    m_run      = 1'b0;
    m_trend    = {1'b1, {(TREND_W-1){1'b0}}};  // half scale
    m_nblur    = 1'b1;
    m_ndo      = 1'b1;
    m_sharp_ok = 1'b0;
    m_sharp    = '0;
    m_cfg      = 4'b1100;
  endtask

  function automatic logic [31:0] model_status();
    logic [31:0] st;
    st            = '0;
    st[0]         = m_ndo;
    st[1]         = m_nblur;
    st[16 +: TREND_W] = m_trend;
    return st;
  endfunction

  // one pixel through estimator and output rules
  task automatic model_pixel(input pixel_t p, output pixel_t exp);
    logic       frame_edge;
    logic       rise;
    logic       blur;
    logic       nblur_old;
    logic       msb_old;
    logic [1:0] d [3];
    frame_edge = m_pre_ok && m_pre.sync.nvsync && !p.sync.nvsync;
    rise       = m_pre_ok && !m_pre.sync.ncsync && p.sync.ncsync;
    blur       = rise ? !m_cfg.vmode : !m_blur;
    nblur_old  = m_nblur;
    msb_old    = m_trend[TREND_W-1];  // trend msb before this edge
    d[0] = dir_of(m_pre.r, p.r);
    d[1] = dir_of(m_pre.g, p.g);
    d[2] = dir_of(m_pre.b, p.b);
    if (m_cfg.n64_480i) begin
      m_run = 1'b0;
    end else begin
      if (!blur)
        m_grad = d;
      else if (reverses(m_grad[0], d[0]) && reverses(m_grad[1], d[1]) &&
               reverses(m_grad[2], d[2]) && (m_cnt < 3))
        m_cnt++;
      if (frame_edge) begin
        if (m_run && (m_cnt >= 2))
          m_trend = (m_trend == {TREND_W{1'b1}}) ? m_trend : m_trend + 1'b1;
        else
          m_trend = (m_trend == '0) ? m_trend : m_trend - 1'b1;
        m_nblur = msb_old;
        m_cnt   = 0;
        m_run   = 1'b1;
      end
    end
    if (frame_edge)
      m_ndo = m_cfg.n64_480i | (m_cfg.nforce_deblur ? nblur_old : m_cfg.ndeblur_man);
    m_pre    = p;
    m_pre_ok = 1'b1;
    m_blur   = blur;
    // output stage
    exp = p;
    if (!m_ndo && blur && m_sharp_ok) begin
      exp.r = m_sharp.r;
      exp.g = m_sharp.g;
      exp.b = m_sharp.b;
    end
    if (!blur) begin
      m_sharp    = p;
      m_sharp_ok = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // bus and APB drivers

  task automatic send_pixel(input pixel_t p);
    pixel_t exp;
    @(posedge nCLK);
    nDSYNC_i <= 1'b0;  // sync word
    d_i      <= COLOR_W'(p.sync);
    @(posedge nCLK);
    nDSYNC_i <= 1'b1;
    d_i      <= p.r;
    @(posedge nCLK);
    d_i      <= p.g;
    @(posedge nCLK);
    d_i      <= p.b;
    model_pixel(p, exp);
    exp_q.push_back(exp);
    cyc_q.push_back(cyc);
  endtask

  task automatic idle_pixels(input int n);
    for (int i = 0; i < n; i++)
      send_pixel('{sync: vsync_t'(4'h4), r: '0, g: '0, b: '0});  // vsync level, black
  endtask

  task automatic send_frame(input logic alt);
    pixel_t p;
    for (int i = 0; i < ACTIVE_N; i++) begin
      p.sync = vsync_t'(4'hF);
      if (alt) begin
        p.r = (i % 2 == 0) ? 7'h7F : 7'h00;  // every pair reverses
        p.g = p.r;
        p.b = p.r;
      end else begin
        p.r = {2'b01, 5'($urandom)};  // msbs fixed, flat gradient
        p.g = {2'b01, 5'($urandom)};
        p.b = {2'b01, 5'($urandom)};
      end
      send_pixel(p);
    end
    idle_pixels(SYNC_N);  // falling nvsync closes the frame
  endtask

  task automatic apb_write(input logic [2:0] addr, input logic [31:0] data);
    @(posedge nCLK);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge nCLK);
    penable_i <= 1'b1;
    @(posedge nCLK);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_read(input logic [2:0] addr, output logic [31:0] data);
    @(posedge nCLK);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge nCLK);
    penable_i <= 1'b1;
    @(posedge nCLK);
    data       = prdata_o;  // end of access cycle
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic wait_drain();
    for (int i = 0; (i < 40) && (exp_q.size() != 0); i++)
      @(posedge nCLK);
    if (exp_q.size() != 0)
      stop_on_error("video output stalled with pixels still pending");
  endtask

  task automatic reset_dut();
    wait_drain();
    @(posedge nCLK);
    nRST     <= 1'b0;
    nDSYNC_i <= 1'b1;
    d_i      <= '0;
    repeat (8) @(posedge nCLK);
    nRST <= 1'b1;
    reset_model();
  endtask

  // write CTRL and read STATUS while the bus keeps running
  task automatic ctrl_live(input logic [31:0] ctrl);
    m_cfg = deblur_cfg_t'(ctrl[3:0]);
    fork
      apb_write(ADDR_CTRL, ctrl);
      idle_pixels(4);
    join
  endtask

  task automatic status_live(input logic [31:0] exp_file);
    logic [31:0] rd;
    fork
      apb_read(ADDR_STATUS, rd);
      idle_pixels(4);
    join
    if (model_status() !== exp_file)
      stop_on_error("vector file expectation does not match the reference model");
    check_word("STATUS", rd, exp_file);
  endtask

  ////////////////////////////////////////
  // output monitor

  always @(posedge nCLK) begin : out_mon
    pixel_t      exp;
    int unsigned c;
    if (nRST && vout_valid_o) begin
      if (exp_q.size() == 0) begin
        stop_on_error("output pixel appeared without a matching input pixel");
      end else begin
        exp = exp_q.pop_front();
        c   = cyc_q.pop_front();
        check_pixel("vout_o", vout_o, exp);
        if (cyc - c != 3)
          stop_on_error($sformatf("output latency was %0d cycles instead of 3", cyc - c));
      end
    end
  end

  // run limit
  initial begin
    for (int i = 0; i < 200000; i++)
      @(posedge nCLK);
    stop_on_error("simulation did not finish within the cycle limit");
  end

  ////////////////////////////////////////
  // main sequence

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] rd;
    logic [31:0] ca, fa, pa, ea, cb, fb, pb, eb;
    nRST      <= 1'b0;
    nDSYNC_i  <= 1'b1;
    d_i       <= '0;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= '0;
    pwdata_i  <= '0;
    cyc        = 0;
    void'($urandom(95177));
    reset_model();
    reset_dut();

    // register access after reset
    apb_read(ADDR_STATUS, rd);
    check_word("STATUS", rd, model_status());
    apb_write(ADDR_CTRL, 32'h9);
    apb_read(ADDR_CTRL, rd);
    check_word("CTRL", rd, 32'h9);
    apb_write(ADDR_STATUS, 32'hFFFF_FFFF);  // read only, ignored
    apb_read(ADDR_STATUS, rd);
    check_word("STATUS", rd, model_status());
    apb_read(ADDR_CTRL, rd);
    check_word("CTRL", rd, 32'h9);  // STATUS write leaves CTRL alone

    fd = $fopen("verification/deblur_vectors.txt", "r");
    if (fd == 0)
      stop_on_error("cannot open the vector file");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if ((n > 1) && (line.getc(0) != "#")) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h", ca, fa, pa, ea, cb, fb, pb, eb);
        if (n == 8) begin
          reset_dut();
          ctrl_live(ca);
          repeat (fa) send_frame(pa[0]);
          status_live(ea);
          ctrl_live(cb);
          repeat (fb) send_frame(pb[0]);
          status_live(eb);
        end
      end
    end
    $fclose(fd);
    wait_drain();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: verification/deblur_vectors.txt
# columns: ctrl_a frames_a pattern_a status_a ctrl_b frames_b pattern_b status_b (hex)
# ctrl bits 3..0 = ndeblur_man nforce_deblur n64_480i vmode, pattern 1 = alternating, 0 = flat
# auto estimation, alternating raises, then one flat frame with vmode 0
D 4 1 01020003 C 1 0 01010003
# auto estimation, flat frames lower the trend, alternating ones raise it again
D 3 0 00FD0000 D 2 1 00FF0000
# manual deblur on, then manual off with estimation still running
1 2 1 01000000 9 1 0 00FF0003
# 480i holds the trend, first frame after clearing only falls
F 2 1 01000003 D 3 1 01010002

// File: vlog.f
src/n64_video_pkg.sv
src/n64_vdemux.sv
src/n64_deblur.sv
src/n64_deblur_out.sv
src/n64_cfg_apb.sv
src/n64_video_top.sv
verification/n64_tb_clk.sv
verification/n64_video_tb.sv

// File: Bender.yml
package:
  name: n64_video_deblur

sources:
  - files:
      - src/n64_video_pkg.sv
      - src/n64_vdemux.sv
      - src/n64_deblur.sv
      - src/n64_deblur_out.sv
      - src/n64_cfg_apb.sv
      - src/n64_video_top.sv
  - target: test
    files:
      - verification/n64_tb_clk.sv
      - verification/n64_video_tb.sv
